//--- project.f
+incdir+include
source/core_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/register_file.sv
source/core_top.sv
tb/tb_instr_memory.sv
tb/tb_core_top.sv

//--- run.sh
#!/bin/sh
# Builds the core testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module tb_core_top \
	-f project.f \
	--Mdir obj_dir -o tb_core_top_sim

./obj_dir/tb_core_top_sim > sim.log
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
	exit 0
else
	exit 1
fi

//--- tb/tb_core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module tb_core_top import core_pkg::*; ();

	localparam int RETIRE_TARGET = 2000;
	localparam int WAIT_LIMIT    = 40;

	logic      clock;
	logic      arst_n;
	wire       fetch_req;
	word_t     fetch_addr;
	wire       fetch_valid;
	inst_t     fetch_inst;
	wire       retire_valid;
	word_t     retire_pc;
	inst_t     retire_inst;
	reg_addr_t retire_rd;
	wire       retire_wen;
	word_t     retire_data;
	word_t     retire_next_pc;
	wire       retire_illegal;

	word_t model_regs [`CORE_REG_COUNT];
	word_t model_pc;
	int    value_errors;
	int    protocol_errors;
	int    timeout_errors;
	int    retired;

	core_top UUT (
		.clock          (clock),
		.arst_n         (arst_n),
		.fetch_req      (fetch_req),
		.fetch_addr     (fetch_addr),
		.fetch_valid    (fetch_valid),
		.fetch_inst     (fetch_inst),
		.retire_valid   (retire_valid),
		.retire_pc      (retire_pc),
		.retire_inst    (retire_inst),
		.retire_rd      (retire_rd),
		.retire_wen     (retire_wen),
		.retire_data    (retire_data),
		.retire_next_pc (retire_next_pc),
		.retire_illegal (retire_illegal)
	);

	tb_instr_memory imem (
		.clock       (clock),
		.arst_n      (arst_n),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.fetch_valid (fetch_valid),
		.fetch_inst  (fetch_inst)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic inst_t program_word(input word_t pc);
		word_t offset;
		offset = (pc - `CORE_RESET_PC) >> 2;
		return imem.mem[offset % `CORE_IMEM_WORDS];
	endfunction

	function automatic word_t alu_model(input logic [2:0] f3, input bit alt, input word_t a,
			input word_t b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011:  return (a < b) ? 32'd1 : 32'd0;
			3'b100:  return a ^ b;
			3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic bit branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			3'b110:  return a < b;
			default: return a >= b;
		endcase
	endfunction

	// One architectural step of RV32E without loads, stores or system ops
	function automatic void reference_step(input inst_t ins, input word_t pc,
			output reg_addr_t rd, output bit wen, output word_t data,
			output word_t next_pc, output bit illegal);
		logic [2:0] f3;
		logic [6:0] f7;
		word_t      a;
		word_t      b;
		word_t      imm_i;
		word_t      imm_u;
		bit         has_rd;
		f3      = ins[14:12];
		f7      = ins[31:25];
		a       = model_regs[ins[18:15]];
		b       = model_regs[ins[23:20]];
		imm_i   = {{20{ins[31]}}, ins[31:20]};
		imm_u   = {ins[31:12], 12'h000};
		rd      = ins[10:7];
		data    = '0;
		next_pc = pc + 32'd4;
		has_rd  = 1'b1;
		case (ins[6:0])
			7'b0110111: begin
				data    = imm_u;
				illegal = ins[11];
			end
			7'b0010111: begin
				data    = pc + imm_u;
				illegal = ins[11];
			end
			7'b1101111: begin
				data    = pc + 32'd4;
				next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
				illegal = ins[11];
			end
			7'b1100111: begin
				data    = pc + 32'd4;
				next_pc = (a + imm_i) & ~32'd1;
				illegal = f3 != 3'b000 || ins[11] || ins[19];
			end
			7'b1100011: begin
				has_rd  = 1'b0;
				illegal = ins[19] || ins[24] || f3 == 3'b010 || f3 == 3'b011;
				if (branch_taken(f3, a, b)) begin
					next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
				end
			end
			7'b0010011: begin
				data    = alu_model(f3, f3 == 3'b101 && f7[5], a, imm_i);
				illegal = ins[11] || ins[19] || (f3 == 3'b001 && f7 != 7'h00) ||
				          (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
			end
			7'b0110011: begin
				data    = alu_model(f3, f7[5], a, b);
				illegal = ins[11] || ins[19] || ins[24] ||
				          !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
			end
			default: illegal = 1'b1;
		endcase
		if (illegal) next_pc = pc + 32'd4;
		wen = !illegal && has_rd && ins[11:7] != 5'd0;
	endfunction

	task automatic compare_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("** Error at %0d ns: %s is x%0d, expected x%0d", $time, what, got, exp);
		end
	endtask

	task automatic compare_flag(input string what, input bit got, input bit exp);
		if (got !== exp) begin
			value_errors++;
			$display("** Error at %0d ns: %s is %0b, expected %0b", $time, what, got, exp);
		end
	endtask

	task automatic wait_fetch_req(output int cycles, output bit ok);
		ok = 1'b0;
		for (cycles = 1; cycles <= WAIT_LIMIT; cycles++) begin
			@(posedge clock);
			if (fetch_req) begin
				ok = 1'b1;
				return;
			end
		end
		timeout_errors++;
		$display("Timeout: the core issued no fetch request within %0d cycles", WAIT_LIMIT);
	endtask

	task automatic wait_fetch_response(output bit ok);
		ok = 1'b0;
		for (int i = 0; i < WAIT_LIMIT; i++) begin
			@(posedge clock);
			if (fetch_req || retire_valid) begin
				protocol_errors++;
				$display("A fetch request or retire appeared while a fetch was outstanding");
			end
			if (fetch_valid) begin
				ok = 1'b1;
				return;
			end
		end
		timeout_errors++;
		$display("Timeout: the instruction memory gave no answer within %0d cycles", WAIT_LIMIT);
	endtask

	task automatic wait_retire(output int cycles, output bit ok);
		ok = 1'b0;
		for (cycles = 1; cycles <= WAIT_LIMIT; cycles++) begin
			@(posedge clock);
			if (fetch_req) begin
				protocol_errors++;
				$display("A new fetch request appeared before the previous instruction retired");
			end
			if (retire_valid) begin
				ok = 1'b1;
				return;
			end
		end
		timeout_errors++;
		$display("Timeout: no instruction retired within %0d cycles of its fetch", WAIT_LIMIT);
	endtask

	initial begin
		inst_t     exp_inst;
		reg_addr_t exp_rd;
		bit        exp_wen;
		word_t     exp_data;
		word_t     exp_next;
		bit        exp_illegal;
		bit        ok;
		int        cycles;
		value_errors    = 0;
		protocol_errors = 0;
		timeout_errors  = 0;
		retired         = 0;
		model_pc        = `CORE_RESET_PC;
		for (int i = 0; i < `CORE_REG_COUNT; i++) begin
			model_regs[i] = '0;
		end
		arst_n <= 1'b0;
		for (int i = 0; i < 8; i++) begin
			@(posedge clock);
			if (fetch_req || retire_valid) begin
				protocol_errors++;
				$display("A fetch or retire strobe was active while reset was asserted");
			end
		end
		arst_n <= 1'b1;
		for (int n = 0; n < RETIRE_TARGET; n++) begin
			wait_fetch_req(cycles, ok);
			if (!ok) break;
			// First request follows the first edge after release, later ones follow retire
			if (cycles != ((n == 0) ? 2 : 1)) begin
				value_errors++;
				$display("** Error at %0d ns: fetch gap is %0d cycles, expected %0d",
				         $time, cycles, (n == 0) ? 2 : 1);
			end
			compare_word("fetch_addr", fetch_addr, model_pc);
			wait_fetch_response(ok);
			if (!ok) break;
			wait_retire(cycles, ok);
			if (!ok) break;
			if (cycles != 3) begin
				value_errors++;
				$display("** Error at %0d ns: retire came %0d cycles after fetch, expected 3",
				         $time, cycles);
			end
			exp_inst = program_word(model_pc);
			reference_step(exp_inst, model_pc, exp_rd, exp_wen, exp_data, exp_next, exp_illegal);
			compare_word("retire_pc", retire_pc, model_pc);
			compare_word("retire_inst", retire_inst, exp_inst);
			compare_flag("retire_illegal", retire_illegal, exp_illegal);
			compare_flag("retire_wen", retire_wen, exp_wen);
			if (exp_wen) begin
				compare_reg("retire_rd", retire_rd, exp_rd);
				compare_word("retire_data", retire_data, exp_data);
				model_regs[exp_rd] = exp_data;
			end
			compare_word("retire_next_pc", retire_next_pc, exp_next);
			model_pc = exp_next;
			retired++;
		end
		$display("Retired %0d of %0d: %0d value errors, %0d protocol errors, %0d timeouts",
		         retired, RETIRE_TARGET, value_errors, protocol_errors, timeout_errors);
		if (value_errors + protocol_errors + timeout_errors == 0 && retired == RETIRE_TARGET) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/tb_instr_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module tb_instr_memory import core_pkg::*; (
	input  wire        clock,
	input  wire        arst_n,
	input  wire        fetch_req,
	input  wire word_t fetch_addr,
	output logic       fetch_valid,
	output inst_t      fetch_inst
);

	inst_t mem [`CORE_IMEM_WORDS];

	function automatic logic [4:0] reg_field();
		if ($urandom_range(15) == 0) return 5'($urandom_range(31, 16)); // Beyond RV32E
		return 5'($urandom_range(15));
	endfunction

	function automatic word_t jump_offset();
		int k;
		k = int'($urandom_range(23)) - 8;
		if (k >= 0) k++; // Never zero, so a jump always moves
		return word_t'(k * 4);
	endfunction

	function automatic inst_t random_inst();
		word_t      r;
		word_t      off;
		logic [2:0] f3;
		logic [6:0] f7;
		r  = $urandom();
		f3 = r[14:12];
		case ($urandom_range(15))
			0: return {r[31:12], reg_field(), 7'b0110111};
			1: return {r[31:12], reg_field(), 7'b0010111};
			2, 3, 4, 5: begin
				f7 = (f3 == 3'b101 && r[30]) ? 7'b0100000 : 7'b0000000;
				if (f3 == 3'b001 || f3 == 3'b101) begin
					return {f7, r[24:20], reg_field(), f3, reg_field(), 7'b0010011};
				end
				return {r[31:20], reg_field(), f3, reg_field(), 7'b0010011};
			end
			6, 7, 8, 9, 15: begin
				f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[30]) ? 7'b0100000 : 7'b0000000;
				return {f7, reg_field(), reg_field(), f3, reg_field(), 7'b0110011};
			end
			10, 11: begin
				if (f3[2:1] == 2'b01) f3[1] = 1'b0; // Map the two reserved codes to BEQ and BNE
				off = jump_offset();
				return {off[12], off[10:5], reg_field(), reg_field(), f3, off[4:1], off[11],
				        7'b1100011};
			end
			12: begin
				off = jump_offset();
				return {off[20], off[10:1], off[11], off[19:12], reg_field(), 7'b1101111};
			end
			13: begin
				off = word_t'($urandom_range(255)) << 2; // Absolute target off x0, aliases into memory
				return {off[11:0], 5'd0, 3'b000, reg_field(), 7'b1100111};
			end
			default: return {r[31:7], r[0] ? 7'b0000011 : 7'b0100011}; // Load or store
		endcase
	endfunction

	// Memory aliases every 1 KiB so that any pc hits a program word
	initial begin
		int unsigned latency;
		word_t       offset;
		fetch_valid <= 1'b0;
		fetch_inst  <= '0;
		void'($urandom(80599));
		for (int i = 0; i < `CORE_IMEM_WORDS; i++) begin
			mem[i] = random_inst();
		end
		forever begin
			@(posedge clock);
			fetch_valid <= 1'b0;
			if (arst_n && fetch_req) begin
				latency = $urandom_range(4, 1);
				offset  = (fetch_addr - `CORE_RESET_PC) >> 2;
				repeat (latency - 1) @(posedge clock);
				fetch_valid <= 1'b1;
				fetch_inst  <= mem[offset % `CORE_IMEM_WORDS];
			end
		end
	end

endmodule

`default_nettype wire

//--- source/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; (
	input  wire            clock,
	input  wire            arst_n,
	output wire            fetch_req,
	output wire word_t     fetch_addr,
	input  wire            fetch_valid,
	input  wire inst_t     fetch_inst,
	output wire            retire_valid,
	output wire word_t     retire_pc,
	output wire inst_t     retire_inst,
	output wire reg_addr_t retire_rd,
	output wire            retire_wen,
	output wire word_t     retire_data,
	output wire word_t     retire_next_pc,
	output wire            retire_illegal
);

	wire             inst_valid;
	wire inst_t      inst;
	wire word_t      inst_pc;
	wire reg_addr_t  rs1;
	wire reg_addr_t  rs2;
	wire word_t      rs1_data;
	wire word_t      rs2_data;
	wire             dec_valid;
	wire word_t      dec_pc;
	wire inst_t      dec_inst;
	wire reg_addr_t  dec_rd;
	wire             dec_wen;
	wire             dec_illegal;
	wire alu_op_t    dec_alu_op;
	wire branch_op_t dec_branch_op;
	wire word_t      dec_a;
	wire word_t      dec_b;
	wire word_t      dec_src2;
	wire word_t      dec_imm;

	fetch_unit u_fetch (
		.clock          (clock),
		.arst_n         (arst_n),
		.fetch_req      (fetch_req),
		.fetch_addr     (fetch_addr),
		.fetch_valid    (fetch_valid),
		.fetch_inst     (fetch_inst),
		.retire_valid   (retire_valid),
		.retire_next_pc (retire_next_pc),
		.inst_valid     (inst_valid),
		.inst           (inst),
		.inst_pc        (inst_pc)
	);

	decode_unit u_decode (
		.clock         (clock),
		.arst_n        (arst_n),
		.inst_valid    (inst_valid),
		.inst          (inst),
		.inst_pc       (inst_pc),
		.rs1           (rs1),
		.rs2           (rs2),
		.rs1_data      (rs1_data),
		.rs2_data      (rs2_data),
		.dec_valid     (dec_valid),
		.dec_pc        (dec_pc),
		.dec_inst      (dec_inst),
		.dec_rd        (dec_rd),
		.dec_wen       (dec_wen),
		.dec_illegal   (dec_illegal),
		.dec_alu_op    (dec_alu_op),
		.dec_branch_op (dec_branch_op),
		.dec_a         (dec_a),
		.dec_b         (dec_b),
		.dec_src2      (dec_src2),
		.dec_imm       (dec_imm)
	);

	execute_unit u_execute (
		.clock          (clock),
		.arst_n         (arst_n),
		.dec_valid      (dec_valid),
		.dec_pc         (dec_pc),
		.dec_inst       (dec_inst),
		.dec_rd         (dec_rd),
		.dec_wen        (dec_wen),
		.dec_illegal    (dec_illegal),
		.dec_alu_op     (dec_alu_op),
		.dec_branch_op  (dec_branch_op),
		.dec_a          (dec_a),
		.dec_b          (dec_b),
		.dec_src2       (dec_src2),
		.dec_imm        (dec_imm),
		.retire_valid   (retire_valid),
		.retire_pc      (retire_pc),
		.retire_inst    (retire_inst),
		.retire_rd      (retire_rd),
		.retire_wen     (retire_wen),
		.retire_data    (retire_data),
		.retire_next_pc (retire_next_pc),
		.retire_illegal (retire_illegal)
	);

	// retire_wen is already qualified by retire_valid
	register_file u_regs (
		.clock    (clock),
		.arst_n   (arst_n),
		.rs1      (rs1),
		.rs2      (rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wen      (retire_wen),
		.rd       (retire_rd),
		.wdata    (retire_data)
	);

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module register_file import core_pkg::*; (
	input  wire            clock,
	input  wire            arst_n,
	input  wire reg_addr_t rs1,
	input  wire reg_addr_t rs2,
	output word_t          rs1_data,
	output word_t          rs2_data,
	input  wire            wen,
	input  wire reg_addr_t rd,
	input  wire word_t     wdata
);

	word_t regs [`CORE_REG_COUNT];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CORE_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1]; // x0 is hardwired
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- source/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit import core_pkg::*; (
	input  wire             clock,
	input  wire             arst_n,
	input  wire             dec_valid,
	input  wire word_t      dec_pc,
	input  wire inst_t      dec_inst,
	input  wire reg_addr_t  dec_rd,
	input  wire             dec_wen,
	input  wire             dec_illegal,
	input  wire alu_op_t    dec_alu_op,
	input  wire branch_op_t dec_branch_op,
	input  wire word_t      dec_a,
	input  wire word_t      dec_b,
	input  wire word_t      dec_src2,
	input  wire word_t      dec_imm,
	output logic            retire_valid,
	output word_t           retire_pc,
	output inst_t           retire_inst,
	output reg_addr_t       retire_rd,
	output logic            retire_wen,
	output word_t           retire_data,
	output word_t           retire_next_pc,
	output logic            retire_illegal
);

	word_t      alu_result;
	word_t      link_pc;
	word_t      next_pc;
	word_t      wb_data;
	logic [4:0] shamt;
	logic       taken;
	logic       is_jump;

	assign shamt   = dec_b[4:0];
	assign link_pc = dec_pc + 32'd4;
	assign is_jump = (dec_branch_op == br_jal) || (dec_branch_op == br_jalr);

	always_comb begin
		case (dec_alu_op)
			alu_add:    alu_result = dec_a + dec_b;
			alu_sub:    alu_result = dec_a - dec_b;
			alu_sll:    alu_result = dec_a << shamt;
			alu_slt:    alu_result = {31'b0, $signed(dec_a) < $signed(dec_b)};
			alu_sltu:   alu_result = {31'b0, dec_a < dec_b};
			alu_xor:    alu_result = dec_a ^ dec_b;
			alu_srl:    alu_result = dec_a >> shamt;
			alu_sra:    alu_result = word_t'($signed(dec_a) >>> shamt);
			alu_or:     alu_result = dec_a | dec_b;
			alu_and:    alu_result = dec_a & dec_b;
			alu_pass_b: alu_result = dec_b;
			default:    alu_result = '0;
		endcase
	end

	// dec_a holds the rs1 value for branches and JALR
	always_comb begin
		case (dec_branch_op)
			br_beq:  taken = (dec_a == dec_src2);
			br_bne:  taken = (dec_a != dec_src2);
			br_blt:  taken = ($signed(dec_a) < $signed(dec_src2));
			br_bge:  taken = ($signed(dec_a) >= $signed(dec_src2));
			br_bltu: taken = (dec_a < dec_src2);
			br_bgeu: taken = (dec_a >= dec_src2);
			br_jal:  taken = 1'b1;
			br_jalr: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (dec_illegal) begin
			next_pc = link_pc;
		end else if (dec_branch_op == br_jalr) begin
			next_pc = (dec_a + dec_imm) & ~32'd1;
		end else if (taken) begin
			next_pc = dec_pc + dec_imm;
		end else begin
			next_pc = link_pc;
		end
	end

	assign wb_data = dec_illegal ? '0 : (is_jump ? link_pc : alu_result);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			retire_valid <= 1'b0;
			retire_wen   <= 1'b0;
		end else begin
			retire_valid <= dec_valid;
			retire_wen   <= dec_valid && dec_wen; // Doubles as the register write strobe
		end
	end

	always_ff @(posedge clock) begin
		if (dec_valid) begin
			retire_pc      <= dec_pc;
			retire_inst    <= dec_inst;
			retire_rd      <= dec_rd;
			retire_data    <= wb_data;
			retire_next_pc <= next_pc;
			retire_illegal <= dec_illegal;
		end
	end

endmodule

`default_nettype wire

//--- source/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit import core_pkg::*; (
	input  wire        clock,
	input  wire        arst_n,
	input  wire        inst_valid,
	input  wire inst_t inst,
	input  wire word_t inst_pc,
	output reg_addr_t  rs1,
	output reg_addr_t  rs2,
	input  wire word_t rs1_data,
	input  wire word_t rs2_data,
	output logic       dec_valid,
	output word_t      dec_pc,
	output inst_t      dec_inst,
	output reg_addr_t  dec_rd,
	output logic       dec_wen,
	output logic       dec_illegal,
	output alu_op_t    dec_alu_op,
	output branch_op_t dec_branch_op,
	output word_t      dec_a,
	output word_t      dec_b,
	output word_t      dec_src2,
	output word_t      dec_imm
);

	logic [6:0]     opcode;
	logic [2:0]     funct3;
	logic [6:0]     funct7;
	logic [4:0]     rd_field;
	logic [4:0]     rs1_field;
	logic [4:0]     rs2_field;
	word_t          imm_i;
	word_t          imm_u;
	word_t          imm_b;
	word_t          imm_j;
	operand_a_sel_t a_sel;
	alu_op_t        alu_op;
	branch_op_t     branch_op;
	word_t          b_operand;
	word_t          imm;
	logic           bad_op;
	logic           uses_rd;
	logic           uses_rs1;
	logic           uses_rs2;
	logic           illegal;

	function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? alu_sub : alu_add;
			3'b001:  return alu_sll;
			3'b010:  return alu_slt;
			3'b011:  return alu_sltu;
			3'b100:  return alu_xor;
			3'b101:  return alt ? alu_sra : alu_srl;
			3'b110:  return alu_or;
			default: return alu_and;
		endcase
	endfunction

	assign opcode    = inst[6:0];
	assign rd_field  = inst[11:7];
	assign funct3    = inst[14:12];
	assign rs1_field = inst[19:15];
	assign rs2_field = inst[24:20];
	assign funct7    = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	assign rs1 = rs1_field[3:0];
	assign rs2 = rs2_field[3:0];

	always_comb begin
		a_sel     = opa_reg;
		alu_op    = alu_add;
		branch_op = br_none;
		b_operand = rs2_data;
		imm       = imm_i;
		bad_op    = 1'b0;
		uses_rd   = 1'b0;
		uses_rs1  = 1'b0;
		uses_rs2  = 1'b0;
		case (opcode)
			7'b0110111: begin // LUI
				alu_op    = alu_pass_b;
				b_operand = imm_u;
				uses_rd   = 1'b1;
			end
			7'b0010111: begin // AUIPC
				a_sel     = opa_pc;
				b_operand = imm_u;
				uses_rd   = 1'b1;
			end
			7'b1101111: begin // JAL
				branch_op = br_jal;
				imm       = imm_j;
				uses_rd   = 1'b1;
			end
			7'b1100111: begin // JALR
				branch_op = br_jalr;
				uses_rd   = 1'b1;
				uses_rs1  = 1'b1;
				bad_op    = (funct3 != 3'b000);
			end
			7'b1100011: begin
				imm      = imm_b;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				case (funct3)
					3'b000:  branch_op = br_beq;
					3'b001:  branch_op = br_bne;
					3'b100:  branch_op = br_blt;
					3'b101:  branch_op = br_bge;
					3'b110:  branch_op = br_bltu;
					3'b111:  branch_op = br_bgeu;
					default: bad_op = 1'b1;
				endcase
			end
			7'b0010011: begin // OP-IMM, shift amount sits in imm_i[4:0]
				alu_op    = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
				b_operand = imm_i;
				uses_rd   = 1'b1;
				uses_rs1  = 1'b1;
				bad_op    = (funct3 == 3'b001 && funct7 != 7'b0000000) ||
				            (funct3 == 3'b101 && funct7 != 7'b0000000 &&
				             funct7 != 7'b0100000);
			end
			7'b0110011: begin
				alu_op   = arith_op(funct3, funct7[5]);
				uses_rd  = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				bad_op   = !(funct7 == 7'b0000000 || (funct7 == 7'b0100000 &&
				             (funct3 == 3'b000 || funct3 == 3'b101)));
			end
			default: bad_op = 1'b1;
		endcase
	end

	// Only the register fields an instruction really uses can make it illegal
	assign illegal = bad_op || (uses_rd && rd_field[4]) || (uses_rs1 && rs1_field[4]) ||
	                 (uses_rs2 && rs2_field[4]);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= inst_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (inst_valid) begin
			dec_pc        <= inst_pc;
			dec_inst      <= inst;
			dec_rd        <= rd_field[3:0];
			dec_wen       <= uses_rd && !illegal && rd_field != 5'd0;
			dec_illegal   <= illegal;
			dec_alu_op    <= alu_op;
			dec_branch_op <= branch_op;
			dec_a         <= (a_sel == opa_pc) ? inst_pc : rs1_data;
			dec_b         <= b_operand;
			dec_src2      <= rs2_data;
			dec_imm       <= imm;
		end
	end

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module fetch_unit import core_pkg::*; (
	input  wire        clock,
	input  wire        arst_n,
	output logic       fetch_req,
	output word_t      fetch_addr,
	input  wire        fetch_valid,
	input  wire inst_t fetch_inst,
	input  wire        retire_valid,
	input  wire word_t retire_next_pc,
	output logic       inst_valid,
	output inst_t      inst,
	output word_t      inst_pc
);

	core_state_t state;
	word_t       pc;

	assign fetch_addr = pc;
	assign inst_pc    = pc;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state      <= st_fetch_issue;
			pc         <= `CORE_RESET_PC;
			fetch_req  <= 1'b0;
			inst_valid <= 1'b0;
		end else begin
			fetch_req  <= 1'b0; // Both are single-cycle strobes
			inst_valid <= 1'b0;
			case (state)
				st_fetch_issue: begin
					fetch_req <= 1'b1;
					state     <= st_fetch_wait;
				end
				st_fetch_wait: begin
					if (fetch_valid) begin
						inst_valid <= 1'b1;
						state      <= st_decode;
					end
				end
				st_decode: begin
					state <= st_execute;
				end
				st_execute: begin
					// Next address is only known once the instruction retires
					if (retire_valid) begin
						pc        <= retire_next_pc;
						fetch_req <= 1'b1;
						state     <= st_fetch_wait;
					end
				end
				default: state <= st_fetch_issue;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == st_fetch_wait && fetch_valid) begin
			inst <= fetch_inst;
		end
	end

endmodule

`default_nettype wire

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [3:0]  reg_addr_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b // LUI
	} alu_op_t;

	typedef enum logic [3:0] {
		br_none,
		br_beq,
		br_bne,
		br_blt,
		br_bge,
		br_bltu,
		br_bgeu,
		br_jal,
		br_jalr
	} branch_op_t;

	typedef enum logic {
		opa_reg,
		opa_pc
	} operand_a_sel_t;

	typedef enum logic [1:0] {
		st_fetch_issue,
		st_fetch_wait,
		st_decode,
		st_execute
	} core_state_t;

endpackage

`default_nettype wire

//--- include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Address of the first instruction fetched after reset
`define CORE_RESET_PC 32'h0000_1000

// RV32E architectural register count
`define CORE_REG_COUNT 16

// Testbench program store depth in words
`define CORE_IMEM_WORDS 256

`endif
